// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_spmv_top
FILELIST  := files.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := All checks passed

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(wildcard src/*.sv src/*.svh sim/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail
run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== files.f ====
+incdir+src
src/spmv_pkg.sv
src/sync_fifo.sv
src/weight_bram.sv
src/row_feeder.sv
src/sparse_pe.sv
src/spmv_top.sv
sim/tb_spmv_top.sv

// ==== sim/tb_spmv_top.sv ====
`timescale 1ns/1ps

`include "spmv_consts.svh"

module tb_spmv_top import spmv_pkg::*; ();

  localparam int DW     = `SPMV_DATA_W;
  localparam int COL_W  = `SPMV_COL_W;
  localparam int LEN_W  = `SPMV_LEN_W;
  localparam int ROW_W  = `SPMV_ROW_W;
  localparam int FEAT_N = `SPMV_FEAT_N;
  localparam int MAX_V  = `SPMV_MAX;
  localparam int NZ_DEPTH = `SPMV_NZ_DEPTH;
  localparam int CLK_NS = 8;
  // weight load plus an upper bound on the cycles of all tests
  localparam int TEST_CYCLES = 1000;
  localparam int WATCHDOG_NS = (FEAT_N + TEST_CYCLES) * CLK_NS;
  localparam int DRAIN_LIMIT = 200;

  logic                clk;
  logic                rst_n;
  logic                wr_en_i;
  logic [COL_W-1:0]    wr_addr_i;
  logic [DW-1:0]       wr_data_i;
  logic                row_start_i;
  logic [LEN_W-1:0]    row_length_i;
  logic                nz_valid_i;
  nz_entry_t           nz_i;
  logic                fifo_full_o;
  logic                result_valid_o;
  row_result_t         result_o;

  logic [DW-1:0]       w_model [FEAT_N];
  logic [COL_W-1:0]    row_cols [$];
  logic [DW-1:0]       row_vals [$];
  row_result_t         exp_q [$];
  row_result_t         got_q [$];
  logic [ROW_W-1:0]    next_row;
  integer              seed;
  int                  errors;
  int                  checks;

  spmv_top i_spmv_top (
    .clk            (clk),
    .rst_n          (rst_n),
    .wr_en_i        (wr_en_i),
    .wr_addr_i      (wr_addr_i),
    .wr_data_i      (wr_data_i),
    .row_start_i    (row_start_i),
    .row_length_i   (row_length_i),
    .nz_valid_i     (nz_valid_i),
    .nz_i           (nz_i),
    .fifo_full_o    (fifo_full_o),
    .result_valid_o (result_valid_o),
    .result_o       (result_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  // results are stable at the falling edge
  always @(negedge clk) begin
    if (rst_n && result_valid_o) begin
      got_q.push_back(result_o);
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Checks failed");
    $finish;
  end

  task automatic check_result(input string name, input row_result_t want,
                              input row_result_t got);
    checks++;
    if (got !== want) begin
      $display("Error %s: expected row %0d sum %0d, actual row %0d sum %0d",
               name, want.row, want.sum, got.row, got.sum);
      errors++;
    end
  endtask

  task automatic check_latency(input string name, input integer want, input integer got);
    checks++;
    if (got !== want) begin
      $display("Error %s: expected latency %0d, actual latency %0d", name, want, got);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic want, input logic got);
    checks++;
    if (got !== want) begin
      $display("Error %s: expected full %0d, actual full %0d", name, want, got);
      errors++;
    end
  endtask

  function automatic logic [DW-1:0] fill_weight(input int a);
    return DW'(a * 37 + (a >> 8) * 11 + 1);
  endfunction

  // saturating sum of products of the row held in row_cols and row_vals
  function automatic logic [DW-1:0] model_sum();
    int i;
    int p;
    int acc;
    acc = 0;
    for (i = 0; i < row_cols.size(); i++) begin
      p = int'(row_vals[i]) * int'(w_model[row_cols[i]]);
      if (p > MAX_V) p = MAX_V;
      acc = acc + p;
      if (acc > MAX_V) acc = MAX_V;
    end
    return DW'(acc);
  endfunction

  function automatic void clear_row();
    row_cols.delete();
    row_vals.delete();
  endfunction

  function automatic void add_nz(input int col, input int val);
    row_cols.push_back(COL_W'(col));
    row_vals.push_back(DW'(val));
  endfunction

  task automatic build_random_row(input int len);
    int i;
    clear_row();
    for (i = 0; i < len; i++) begin
      add_nz(int'($unsigned($random(seed)) % FEAT_N), int'(DW'($random(seed))));
    end
  endtask

  task automatic put_weight(input int col, input int w);
    @(posedge clk);
    wr_en_i   <= 1'b1;
    wr_addr_i <= COL_W'(col);
    wr_data_i <= DW'(w);
    w_model[col] = DW'(w);
  endtask

  task automatic stop_weight_writes();
    @(posedge clk);
    wr_en_i <= 1'b0;
  endtask

  task automatic load_weights();
    int a;
    for (a = 0; a < FEAT_N; a++) begin
      put_weight(a, int'(fill_weight(a)));
    end
    stop_weight_writes();
  endtask

  task automatic drive_cycle(input logic hdr, input logic [LEN_W-1:0] len,
                             input logic nz_en, input nz_entry_t nz);
    @(posedge clk);
    row_start_i  <= hdr;
    row_length_i <= len;
    nz_valid_i   <= nz_en;
    nz_i         <= nz;
  endtask

  task automatic drive_idle();
    drive_cycle(1'b0, '0, 1'b0, '0);
  endtask

  // idle for a random gap, then hold off while full
  task automatic pause_host(input int gap_max);
    int gap;
    gap = 1 + int'($unsigned($random(seed)) % gap_max);
    repeat (gap) drive_idle();
    @(negedge clk);
    while (fifo_full_o) begin
      @(negedge clk);
    end
  endtask

  // gap_max of zero sends the row with no idle cycles
  task automatic send_row(input int gap_max);
    int n;
    int i;
    n = row_cols.size();
    exp_q.push_back('{row: next_row, sum: model_sum()});
    next_row = next_row + ROW_W'(1);
    if (gap_max > 0) pause_host(gap_max);
    if (n == 0) begin
      drive_cycle(1'b1, '0, 1'b0, '0);
    end else begin
      drive_cycle(1'b1, LEN_W'(n), 1'b1, '{col: row_cols[0], val: row_vals[0]});
    end
    for (i = 1; i < n; i++) begin
      if (gap_max > 0) pause_host(gap_max);
      drive_cycle(1'b0, '0, 1'b1, '{col: row_cols[i], val: row_vals[i]});
    end
  endtask

  task automatic check_rows(input string name);
    int waited;
    row_result_t want;
    row_result_t got;
    waited = 0;
    while (got_q.size() < exp_q.size() && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (got_q.size() < exp_q.size()) begin
      $display("%s: only %0d of %0d row results arrived", name, got_q.size(), exp_q.size());
      errors++;
    end
    while (exp_q.size() > 0 && got_q.size() > 0) begin
      want = exp_q.pop_front();
      got  = got_q.pop_front();
      check_result(name, want, got);
    end
    repeat (4) @(posedge clk);
    if (got_q.size() > 0) begin
      $display("%s: %0d row results came that no row asked for", name, got_q.size());
      errors++;
    end
    got_q.delete();
    exp_q.delete();
  endtask

  task automatic test_single_row();
    integer lat;
    put_weight(10, 3);
    put_weight(11, 5);
    put_weight(12, 7);
    put_weight(13, 9);
    stop_weight_writes();
    clear_row();
    add_nz(10, 2);
    add_nz(11, 4);
    add_nz(12, 6);
    add_nz(13, 8);
    send_row(0);
    lat = 0;
    @(negedge clk);
    while (!result_valid_o && lat < 20) begin
      drive_idle();
      @(negedge clk);
      lat = lat + 1;
    end
    drive_idle();
    // one cycle until the push shows at the FIFO head, then 3 to the result
    check_latency("single_row", 1 + 3, lat);
    check_rows("single_row");
  endtask

  task automatic test_saturation();
    put_weight(100, 200);
    put_weight(101, 15);
    put_weight(102, 5);
    stop_weight_writes();
    // product 40000
    clear_row();
    add_nz(100, 200);
    send_row(0);
    // 150 + 150 passes the maximum
    clear_row();
    add_nz(101, 10);
    add_nz(101, 10);
    add_nz(102, 1);
    send_row(0);
    drive_idle();
    check_rows("saturation");
  endtask

  task automatic test_empty_row();
    clear_row();
    add_nz(20, 3);
    add_nz(21, 2);
    send_row(0);
    clear_row();
    send_row(0);
    clear_row();
    add_nz(22, 1);
    send_row(0);
    drive_idle();
    check_rows("empty_row");
  endtask

  task automatic test_back_to_back();
    build_random_row(3);
    send_row(0);
    build_random_row(1);
    send_row(0);
    build_random_row(5);
    send_row(0);
    drive_idle();
    check_rows("back_to_back");
  endtask

  task automatic test_random_gaps();
    int r;
    for (r = 0; r < 8; r++) begin
      build_random_row(int'($unsigned($random(seed)) % 10));
      send_row(3);
    end
    drive_idle();
    check_rows("random_gaps");
  endtask

  // nonzeros ahead of their header fill the FIFO, the host then waits
  task automatic test_fifo_full();
    int n;
    int i;
    build_random_row(NZ_DEPTH + 2);
    n = row_cols.size();
    exp_q.push_back('{row: next_row, sum: model_sum()});
    next_row = next_row + ROW_W'(1);
    for (i = 0; i < NZ_DEPTH; i++) begin
      drive_cycle(1'b0, '0, 1'b1, '{col: row_cols[i], val: row_vals[i]});
    end
    drive_cycle(1'b1, LEN_W'(n), 1'b0, '0);
    @(negedge clk);
    check_flag("fifo_full", 1'b1, fifo_full_o);
    for (i = NZ_DEPTH; i < n; i++) begin
      pause_host(1);
      drive_cycle(1'b0, '0, 1'b1, '{col: row_cols[i], val: row_vals[i]});
    end
    drive_idle();
    check_rows("fifo_full");
  endtask

  initial begin
    seed         = 24;
    errors       = 0;
    checks       = 0;
    next_row     = '0;
    rst_n        = 1'b0;
    wr_en_i      = 1'b0;
    wr_addr_i    = '0;
    wr_data_i    = '0;
    row_start_i  = 1'b0;
    row_length_i = '0;
    nz_valid_i   = 1'b0;
    nz_i         = '0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if (result_valid_o || fifo_full_o) begin
      $display("outputs are not idle after reset");
      errors++;
    end
    load_weights();
    test_single_row();
    test_saturation();
    test_empty_row();
    test_back_to_back();
    test_random_gaps();
    test_fifo_full();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== src/row_feeder.sv ====
`timescale 1ns/1ps

`include "spmv_consts.svh"

module row_feeder import spmv_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   row_start_i,
  input  logic [`SPMV_LEN_W-1:0] row_length_i,
  input  logic                   nz_valid_i,
  input  nz_entry_t              nz_i,
  output logic                   fifo_full_o,
  output logic                   item_valid_o,
  output pe_item_t               item_o
);

  localparam int LEN_W = `SPMV_LEN_W;

  row_hdr_t         hdr_in;
  row_hdr_t         hdr_head;
  nz_entry_t        nz_head;
  logic             hdr_empty;
  logic             hdr_full;
  logic             nz_empty;
  logic             nz_full;
  logic             hdr_pop;
  logic             nz_pop;
  logic             empty_row;
  logic             row_active_q;
  logic [LEN_W-1:0] remain_q;
  logic [LEN_W-1:0] cur_len;

  assign hdr_in = '{len: row_length_i};

  sync_fifo #(
    .WIDTH ($bits(row_hdr_t)),
    .DEPTH (`SPMV_HDR_DEPTH)
  ) i_hdr_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_i      (row_start_i),
    .push_data_i (hdr_in),
    .pop_i       (hdr_pop),
    .pop_data_o  (hdr_head),
    .empty_o     (hdr_empty),
    .full_o      (hdr_full)
  );

  sync_fifo #(
    .WIDTH ($bits(nz_entry_t)),
    .DEPTH (`SPMV_NZ_DEPTH)
  ) i_nz_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_i      (nz_valid_i),
    .push_data_i (nz_i),
    .pop_i       (nz_pop),
    .pop_data_o  (nz_head),
    .empty_o     (nz_empty),
    .full_o      (nz_full)
  );

  assign fifo_full_o = hdr_full || nz_full;

  // a header is only taken when something can issue in the same cycle
  assign empty_row = !row_active_q && !hdr_empty && (hdr_head.len == '0);
  assign cur_len   = row_active_q ? remain_q : hdr_head.len;
  assign nz_pop    = (row_active_q || (!hdr_empty && !empty_row)) && !nz_empty;
  assign hdr_pop   = empty_row || (!row_active_q && nz_pop);

  assign item_valid_o = nz_pop || empty_row;

  always_comb begin
    item_o.nz    = nz_head;
    item_o.first = !row_active_q;
    item_o.last  = !empty_row && (cur_len == LEN_W'(1));
    item_o.empty = empty_row;
  end

  // remaining count of the open row
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      row_active_q <= 1'b0;
      remain_q     <= '0;
    end else if (nz_pop) begin
      row_active_q <= (cur_len != LEN_W'(1));
      remain_q     <= cur_len - LEN_W'(1);
    end
  end

  // an item needs an open row with count left or a header at the head
  a_item_has_hdr: assert property (@(posedge clk) disable iff (!rst_n)
    item_valid_o |-> (row_active_q ? (remain_q != '0) : !hdr_empty))
    else $error("row_feeder: item issued without a loaded header");

endmodule

// ==== src/sparse_pe.sv ====
`timescale 1ns/1ps

`include "spmv_consts.svh"

module sparse_pe import spmv_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    item_valid_i,
  input  pe_item_t                item_i,
  output logic                    w_rd_en_o,
  output logic [`SPMV_COL_W-1:0]  w_addr_o,
  input  logic [`SPMV_DATA_W-1:0] w_data_i,
  output logic                    result_valid_o,
  output row_result_t             result_o
);

  localparam int DW    = `SPMV_DATA_W;
  localparam int ROW_W = `SPMV_ROW_W;
  localparam logic [DW-1:0] MAX_V = DW'(`SPMV_MAX);

  // stage 1, item waiting for its weight
  logic            s1_valid;
  pe_item_t        s1_item;
  logic [2*DW-1:0] prod_full;
  logic [DW-1:0]   prod_sat;

  // stage 2, clamped product
  logic            s2_valid;
  logic            s2_first;
  logic            s2_last;
  logic            s2_empty;
  logic [DW-1:0]   s2_prod;
  logic [DW:0]     sum_full;
  logic [DW-1:0]   sum_sat;

  // stage 3, running sum and result
  logic [DW-1:0]    acc_q;
  logic             res_valid_q;
  logic [ROW_W-1:0] row_id_q;

  // cycle 0, weight address straight from the item
  assign w_rd_en_o = item_valid_i && !item_i.empty;
  assign w_addr_o  = item_i.nz.col;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= item_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    s1_item <= item_i;
  end

  // cycle 1
  assign prod_full = s1_item.nz.val * w_data_i;

  always_comb begin
    if (s1_item.empty) begin
      prod_sat = '0;
    end else if (prod_full > (2 * DW)'(MAX_V)) begin
      prod_sat = MAX_V;
    end else begin
      prod_sat = prod_full[DW-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s2_valid <= 1'b0;
    end else begin
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    s2_first <= s1_item.first;
    s2_last  <= s1_item.last;
    s2_empty <= s1_item.empty;
    s2_prod  <= prod_sat;
  end

  // cycle 2, first item restarts the sum
  assign sum_full = {1'b0, (s2_first ? '0 : acc_q)} + {1'b0, s2_prod};

  always_comb begin
    if (s2_empty) begin
      sum_sat = '0;
    end else if (sum_full > {1'b0, MAX_V}) begin
      sum_sat = MAX_V;
    end else begin
      sum_sat = sum_full[DW-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      acc_q       <= '0;
      res_valid_q <= 1'b0;
      row_id_q    <= '0;
    end else begin
      if (s2_valid) begin
        acc_q <= sum_sat;
      end
      res_valid_q <= s2_valid && (s2_last || s2_empty);
      // row id moves on after each emitted result
      if (res_valid_q) begin
        row_id_q <= row_id_q + ROW_W'(1);
      end
    end
  end

  // cycle 3
  assign result_valid_o = res_valid_q;
  assign result_o       = '{row: row_id_q, sum: acc_q};

  // a clamped running sum never drops below its last value
  a_sum_no_wrap: assert property (@(posedge clk) disable iff (!rst_n)
    (s2_valid && !s2_first && !s2_empty) |=> (acc_q >= $past(acc_q)))
    else $error("sparse_pe: running sum wrapped instead of clamping");

  a_row_latency: assert property (@(posedge clk) disable iff (!rst_n)
    (item_valid_i && (item_i.last || item_i.empty)) |-> ##3 result_valid_o)
    else $error("sparse_pe: row result not 3 cycles after its last item");

endmodule

// ==== src/spmv_consts.svh ====
`ifndef SPMV_CONSTS_SVH
`define SPMV_CONSTS_SVH

// value and weight width
`define SPMV_DATA_W 8

// features per node, also the weight memory size
`define SPMV_FEAT_N 1433

// column index and row length widths
`define SPMV_COL_W 11
`define SPMV_LEN_W 11
`define SPMV_ROW_W 8

// buffer depths
`define SPMV_NZ_DEPTH 16
`define SPMV_HDR_DEPTH 4

// clamp value for products and sums
`define SPMV_MAX 255

`endif

// ==== src/spmv_pkg.sv ====
`include "spmv_consts.svh"

package spmv_pkg;

  // one compressed nonzero
  typedef struct packed {
    logic [`SPMV_COL_W-1:0]  col;
    logic [`SPMV_DATA_W-1:0] val;
  } nz_entry_t;

  typedef struct packed {
    logic [`SPMV_LEN_W-1:0] len;
  } row_hdr_t;

  // work item handed from feeder to pe
  typedef struct packed {
    nz_entry_t nz;
    logic      first;
    logic      last;
    logic      empty;
  } pe_item_t;

  typedef struct packed {
    logic [`SPMV_ROW_W-1:0]  row;
    logic [`SPMV_DATA_W-1:0] sum;
  } row_result_t;

endpackage

// ==== src/spmv_top.sv ====
`timescale 1ns/1ps

`include "spmv_consts.svh"

module spmv_top import spmv_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    wr_en_i,
  input  logic [`SPMV_COL_W-1:0]  wr_addr_i,
  input  logic [`SPMV_DATA_W-1:0] wr_data_i,
  input  logic                    row_start_i,
  input  logic [`SPMV_LEN_W-1:0]  row_length_i,
  input  logic                    nz_valid_i,
  input  nz_entry_t               nz_i,
  output logic                    fifo_full_o,
  output logic                    result_valid_o,
  output row_result_t             result_o
);

  logic                    item_valid;
  pe_item_t                item;
  logic                    w_rd_en;
  logic [`SPMV_COL_W-1:0]  w_addr;
  logic [`SPMV_DATA_W-1:0] w_data;

  row_feeder i_row_feeder (
    .clk          (clk),
    .rst_n        (rst_n),
    .row_start_i  (row_start_i),
    .row_length_i (row_length_i),
    .nz_valid_i   (nz_valid_i),
    .nz_i         (nz_i),
    .fifo_full_o  (fifo_full_o),
    .item_valid_o (item_valid),
    .item_o       (item)
  );

  sparse_pe i_sparse_pe (
    .clk            (clk),
    .rst_n          (rst_n),
    .item_valid_i   (item_valid),
    .item_i         (item),
    .w_rd_en_o      (w_rd_en),
    .w_addr_o       (w_addr),
    .w_data_i       (w_data),
    .result_valid_o (result_valid_o),
    .result_o       (result_o)
  );

  // host loads weights here before streaming rows
  weight_bram i_weight_bram (
    .clk       (clk),
    .wr_en_i   (wr_en_i),
    .wr_addr_i (wr_addr_i),
    .wr_data_i (wr_data_i),
    .rd_en_i   (w_rd_en),
    .rd_addr_i (w_addr),
    .rd_data_o (w_data)
  );

endmodule

// ==== src/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 16
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             push_i,
  input  logic [WIDTH-1:0] push_data_i,
  input  logic             pop_i,
  output logic [WIDTH-1:0] pop_data_o,
  output logic             empty_o,
  output logic             full_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  // wraps for depths that are not a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    next_ptr = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
  endfunction

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  assign empty_o    = (count == '0);
  assign full_o     = (count == CNT_W'(DEPTH));
  // head word shows without a pop
  assign pop_data_o = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;
      endcase
    end
  end

  // the host must watch the full level
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    push_i |-> !full_o)
    else $error("sync_fifo: push while full");

  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    pop_i |-> !empty_o)
    else $error("sync_fifo: pop while empty");

endmodule

// ==== src/weight_bram.sv ====
`timescale 1ns/1ps

`include "spmv_consts.svh"

module weight_bram (
  input  logic                    clk,
  input  logic                    wr_en_i,
  input  logic [`SPMV_COL_W-1:0]  wr_addr_i,
  input  logic [`SPMV_DATA_W-1:0] wr_data_i,
  input  logic                    rd_en_i,
  input  logic [`SPMV_COL_W-1:0]  rd_addr_i,
  output logic [`SPMV_DATA_W-1:0] rd_data_o
);

  localparam int DEPTH = `SPMV_FEAT_N;

  logic [`SPMV_DATA_W-1:0] mem [DEPTH];
  logic                    wr_hit;
  logic                    rd_hit;

  // the index space is wider than the feature count
  assign wr_hit = wr_en_i && (int'(wr_addr_i) < DEPTH);
  assign rd_hit = rd_en_i && (int'(rd_addr_i) < DEPTH);

  // host port
  always_ff @(posedge clk) begin
    if (wr_hit) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  // read-first, same address in the same cycle returns old word
  always_ff @(posedge clk) begin
    if (rd_hit) begin
      rd_data_o <= mem[rd_addr_i];
    end else if (rd_en_i) begin
      rd_data_o <= '0;
    end
  end

endmodule
